/* all.f */
+incdir+source
source/dlx_pkg.sv
source/dlx_pipe_if.sv
source/dlx_fetch.sv
source/dlx_decode.sv
source/dlx_reg_file.sv
source/dlx_forward.sv
source/dlx_execute.sv
source/dlx_writeback.sv
source/dlx_core.sv
dv/tb_dlx_core.sv

/* dv/tb_dlx_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module tb_dlx_core import dlx_pkg::*; ();

    localparam int    IMEM_WORDS  = 256;
    localparam int    DMEM_WORDS  = 1024;
    localparam int    RUN_LIMIT   = 2000;
    localparam word_t MARKER_ADDR = 32'h0000_0ffc;

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    // memory models
    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];

    // architectural model state built alongside the program
    word_t model_r [32];
    bit    model_live;
    int    prog_len;
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t got_addr [$];
    word_t got_data [$];

    word_t rng_state;
    int    err_count;
    int    pass_count;
    int    fail_count;

    dlx_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[11:2]] <= dmem_wdata;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // xorshift32
    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic imm16_t rand16();
        word_t r;
        r = next_rand();
        return r[15:0];
    endfunction

    function automatic word_t sext16(input imm16_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // instruction encoders
    function automatic word_t enc_r(input funct_t fn, input reg_idx_t rd,
                                    input reg_idx_t rs1, input reg_idx_t rs2);
        return {`DLX_OP_RTYPE, rs1, rs2, rd, 5'b00000, fn};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input reg_idx_t rt,
                                    input reg_idx_t rs1, input imm16_t imm);
        return {op, rs1, rt, imm};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("error %s expected 0x%08h got 0x%08h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic init_test();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        // hashed fill per word index
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = word_t'(i) * 32'h9e37_79b9 + 32'h1357_9bdf;
        end
        for (int i = 0; i < 32; i++) begin
            model_r[i] = '0;
        end
        model_live = 1'b1;
        prog_len   = 0;
        exp_addr.delete();
        exp_data.delete();
        got_addr.delete();
        got_data.delete();
    endtask

    task automatic put_word(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // r0 is never written in the model
    task automatic set_reg(input reg_idx_t rd, input word_t value);
        if (model_live && (rd != '0)) begin
            model_r[rd] = value;
        end
    endtask

    task automatic emit_r(input funct_t fn, input reg_idx_t rd,
                          input reg_idx_t rs1, input reg_idx_t rs2);
        word_t a;
        word_t b;
        word_t res;
        bit    writes;
        a      = model_r[rs1];
        b      = model_r[rs2];
        writes = 1'b1;
        res    = '0;
        case (fn)
            `DLX_FN_ADD: res = a + b;
            `DLX_FN_SUB: res = a - b;
            `DLX_FN_AND: res = a & b;
            `DLX_FN_OR:  res = a | b;
            `DLX_FN_XOR: res = a ^ b;
            `DLX_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:     writes = 1'b0;
        endcase
        put_word(enc_r(fn, rd, rs1, rs2));
        if (writes) begin
            set_reg(rd, res);
        end
    endtask

    // addi, andi, ori and lw
    task automatic emit_i(input opcode_t op, input reg_idx_t rd,
                          input reg_idx_t rs1, input imm16_t imm);
        word_t a;
        word_t addr;
        word_t res;
        a    = model_r[rs1];
        addr = a + sext16(imm);
        case (op)
            `DLX_OP_ANDI: res = a & {16'h0000, imm};
            `DLX_OP_ORI:  res = a | {16'h0000, imm};
            `DLX_OP_LW:   res = dmem[addr[11:2]];
            default:      res = addr;
        endcase
        put_word(enc_i(op, rd, rs1, imm));
        set_reg(rd, res);
    endtask

    task automatic emit_sw(input reg_idx_t rs2, input reg_idx_t rs1, input imm16_t imm);
        put_word(enc_i(`DLX_OP_SW, rs2, rs1, imm));
        if (model_live) begin
            exp_addr.push_back(model_r[rs1] + sext16(imm));
            exp_data.push_back(model_r[rs2]);
        end
    endtask

    // target lands past three delay slots and skip words
    task automatic emit_branch(input opcode_t op, input reg_idx_t rs1, input int skip,
                               output bit taken);
        put_word(enc_i(op, 5'd0, rs1, imm16_t'((3 + skip) * 4)));
        taken = (model_r[rs1] == '0) == (op == `DLX_OP_BEQZ);
    endtask

    task automatic emit_jump(input int skip);
        put_word({`DLX_OP_J, imm26_t'((3 + skip) * 4)});
    endtask

    // stores after the delay slots that die when the leap is taken
    task automatic skip_region(input bit taken, input int n, input reg_idx_t src,
                               input imm16_t base);
        model_live = !taken;
        for (int i = 0; i < n; i++) begin
            emit_sw(src, 5'd0, base + imm16_t'(4 * i));
        end
        model_live = 1'b1;
    endtask

    task automatic finish_program();
        emit_i(`DLX_OP_ADDI, 5'd31, 5'd0, 16'h600d);
        emit_sw(5'd31, 5'd0, MARKER_ADDR[15:0]);
    endtask

    // three reset cycles with quiet outputs checked throughout
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_word("dmem_we", '0, word_t'(dmem_we));
            check_word("imem_addr", `DLX_RESET_PC, imem_addr);
        end
        rst_n = 1'b1;
        check_word("dmem_we", '0, word_t'(dmem_we));
        check_word("imem_addr", `DLX_RESET_PC, imem_addr);
    endtask

    task automatic run_and_check();
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        apply_reset();
        // log every store until the marker shows up
        while (!done && (cycles < RUN_LIMIT)) begin
            @(negedge clk);
            cycles++;
            if (dmem_we === 1'b1) begin
                got_addr.push_back(dmem_addr);
                got_data.push_back(dmem_wdata);
                done = (dmem_addr == MARKER_ADDR);
            end
        end
        assert (done) else begin
            $display("timeout, the marker store did not arrive within %0d cycles", RUN_LIMIT);
            err_count++;
        end
        assert (got_addr.size() == exp_addr.size()) else begin
            $display("store count mismatch, expected %0d stores but saw %0d",
                     exp_addr.size(), got_addr.size());
            err_count++;
        end
        for (int i = 0; (i < exp_addr.size()) && (i < got_addr.size()); i++) begin
            check_word("dmem_addr", exp_addr[i], got_addr[i]);
            check_word("dmem_wdata", exp_data[i], got_data[i]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("%-14s passed", name);
        end else begin
            fail_count++;
            $display("%-14s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        int errs_before;
        errs_before = err_count;
        init_test();
        finish_program();
        run_and_check();
        report_test("reset", errs_before);
    endtask

    task automatic test_alu_forward();
        int errs_before;
        errs_before = err_count;
        init_test();
        dmem[16] = next_rand();
        dmem[17] = next_rand();
        emit_i(`DLX_OP_LW, 5'd1, 5'd0, 16'h0040);
        emit_i(`DLX_OP_LW, 5'd2, 5'd0, 16'h0044);
        // back to back chain where each reads the one before
        emit_r(`DLX_FN_ADD, 5'd3, 5'd1, 5'd2);
        emit_r(`DLX_FN_SUB, 5'd4, 5'd3, 5'd1);
        emit_r(`DLX_FN_AND, 5'd5, 5'd4, 5'd2);
        emit_r(`DLX_FN_OR, 5'd6, 5'd5, 5'd3);
        emit_r(`DLX_FN_XOR, 5'd7, 5'd6, 5'd4);
        emit_r(`DLX_FN_SLT, 5'd8, 5'd7, 5'd1);
        emit_r(`DLX_FN_SLT, 5'd9, 5'd1, 5'd7);
        for (int r = 3; r <= 9; r++) begin
            emit_sw(reg_idx_t'(r), 5'd0, imm16_t'(16'h0100 + 4 * r));
        end
        // immediates with stores in between
        emit_i(`DLX_OP_ADDI, 5'd10, 5'd9, rand16());
        emit_sw(5'd10, 5'd0, 16'h0140);
        emit_i(`DLX_OP_ANDI, 5'd11, 5'd7, rand16());
        emit_i(`DLX_OP_ORI, 5'd12, 5'd11, rand16());
        emit_sw(5'd11, 5'd0, 16'h0144);
        emit_sw(5'd12, 5'd0, 16'h0148);
        // r0 keeps reading zero
        emit_i(`DLX_OP_ADDI, 5'd0, 5'd12, rand16());
        emit_r(`DLX_FN_ADD, 5'd0, 5'd12, 5'd3);
        emit_r(`DLX_FN_OR, 5'd13, 5'd0, 5'd12);
        emit_sw(5'd0, 5'd0, 16'h014c);
        emit_sw(5'd13, 5'd0, 16'h0150);
        finish_program();
        run_and_check();
        report_test("alu_forward", errs_before);
    endtask

    task automatic test_load_use();
        int errs_before;
        errs_before = err_count;
        init_test();
        emit_i(`DLX_OP_ADDI, 5'd20, 5'd0, rand16());
        emit_i(`DLX_OP_LW, 5'd1, 5'd0, 16'h0080);
        emit_r(`DLX_FN_ADD, 5'd3, 5'd1, 5'd20);
        emit_sw(5'd3, 5'd0, 16'h0200);
        // store data straight from a load
        emit_i(`DLX_OP_LW, 5'd4, 5'd0, 16'h0084);
        emit_sw(5'd4, 5'd0, 16'h0204);
        // load base from the instruction just before
        emit_i(`DLX_OP_ADDI, 5'd5, 5'd0, 16'h0088);
        emit_i(`DLX_OP_LW, 5'd6, 5'd5, 16'h0004);
        emit_r(`DLX_FN_SUB, 5'd7, 5'd6, 5'd3);
        emit_sw(5'd7, 5'd5, 16'h0180);
        emit_sw(5'd6, 5'd0, 16'h020c);
        finish_program();
        run_and_check();
        report_test("load_use", errs_before);
    endtask

    task automatic test_branches();
        int errs_before;
        bit taken;
        imm16_t nz;
        errs_before = err_count;
        init_test();
        nz = rand16() | 16'h0001;
        emit_i(`DLX_OP_ADDI, 5'd1, 5'd0, 16'h0000);
        emit_i(`DLX_OP_ORI, 5'd2, 5'd0, nz);
        // beqz taken
        emit_branch(`DLX_OP_BEQZ, 5'd1, 2, taken);
        emit_sw(5'd2, 5'd0, 16'h0300);
        emit_sw(5'd2, 5'd0, 16'h0304);
        emit_sw(5'd2, 5'd0, 16'h0308);
        skip_region(taken, 2, 5'd2, 16'h0310);
        emit_sw(5'd2, 5'd0, 16'h0320);
        // bnez not taken
        emit_branch(`DLX_OP_BNEZ, 5'd1, 1, taken);
        emit_i(`DLX_OP_ADDI, 5'd3, 5'd2, 16'h0001);
        emit_sw(5'd3, 5'd0, 16'h0330);
        emit_sw(5'd2, 5'd0, 16'h0334);
        skip_region(taken, 1, 5'd3, 16'h0338);
        // beqz not taken
        emit_branch(`DLX_OP_BEQZ, 5'd2, 1, taken);
        emit_sw(5'd3, 5'd0, 16'h0340);
        emit_sw(5'd2, 5'd0, 16'h0344);
        emit_sw(5'd3, 5'd0, 16'h0348);
        skip_region(taken, 1, 5'd2, 16'h034c);
        // bnez taken with its operand from the instruction just before
        emit_i(`DLX_OP_ADDI, 5'd2, 5'd2, 16'h0000);
        emit_branch(`DLX_OP_BNEZ, 5'd2, 2, taken);
        emit_sw(5'd3, 5'd0, 16'h0350);
        emit_sw(5'd2, 5'd0, 16'h0354);
        emit_sw(5'd3, 5'd0, 16'h0358);
        skip_region(taken, 2, 5'd2, 16'h0360);
        emit_sw(5'd3, 5'd0, 16'h0370);
        finish_program();
        run_and_check();
        report_test("branches", errs_before);
    endtask

    task automatic test_jump();
        int errs_before;
        errs_before = err_count;
        init_test();
        emit_i(`DLX_OP_ADDI, 5'd1, 5'd0, rand16());
        emit_jump(3);
        // delay slots
        emit_i(`DLX_OP_ADDI, 5'd2, 5'd1, rand16());
        emit_sw(5'd2, 5'd0, 16'h0400);
        emit_r(`DLX_FN_XOR, 5'd3, 5'd2, 5'd1);
        skip_region(1'b1, 3, 5'd3, 16'h0410);
        // target store with data from the last slot
        emit_sw(5'd3, 5'd0, 16'h0404);
        emit_i(`DLX_OP_ORI, 5'd4, 5'd3, rand16());
        emit_sw(5'd4, 5'd0, 16'h0408);
        finish_program();
        run_and_check();
        report_test("jump", errs_before);
    endtask

    //////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n      = 1'b0;
        rng_state  = 32'd19;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        test_reset();
        test_alu_forward();
        test_load_use();
        test_branches();
        test_jump();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/dlx_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_core import dlx_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    // fetch to decode
    logic     stall;
    word_t    if_pc_plus4;
    word_t    if_instr;

    // decode to register file
    reg_idx_t rf_rs1;
    reg_idx_t rf_rs2;
    word_t    rf_a;
    word_t    rf_b;

    // write-back result
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_value;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    dlx_fetch fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .ex_mem      (ex_mem),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_pc_plus4 (if_pc_plus4),
        .if_instr    (if_instr)
    );

    dlx_decode decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .if_pc_plus4 (if_pc_plus4),
        .if_instr    (if_instr),
        .imem_data   (imem_data),
        .rf_rs1      (rf_rs1),
        .rf_rs2      (rf_rs2),
        .rf_a        (rf_a),
        .rf_b        (rf_b),
        .stall       (stall),
        .id_ex       (id_ex)
    );

    dlx_reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rf_rs1),
        .rs2      (rf_rs2),
        .a        (rf_a),
        .b        (rf_b),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_value (wb_value)
    );

    dlx_execute execute_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_value (wb_value)
    );

    dlx_writeback writeback_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value)
    );

    // data memory straight off EX/MEM
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write;

endmodule

`default_nettype wire

/* source/dlx_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_writeback import dlx_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    ex_mem_if.mem    ex_mem,
    input  word_t    dmem_rdata,
    output logic     wb_we,
    output reg_idx_t wb_rd,
    output word_t    wb_value
);

    word_t    alu_q;
    word_t    load_q;
    reg_idx_t rd_q;
    logic     reg_write_q;
    logic     mem_to_reg_q;

    // MEM/WB controls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end else begin
            reg_write_q  <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
        end
    end

    // payload with load data from the combinational read
    always_ff @(posedge clk) begin
        alu_q  <= ex_mem.alu_result;
        load_q <= dmem_rdata;
        rd_q   <= ex_mem.rd;
    end

    // back to the register file and forwarding
    assign wb_we    = reg_write_q;
    assign wb_rd    = rd_q;
    assign wb_value = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

/* source/dlx_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_execute import dlx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    id_ex_if.execute  id_ex,
    ex_mem_if         ex_mem,
    input  logic      wb_we,
    input  reg_idx_t  wb_rd,
    input  word_t     wb_value
);

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_result;
    word_t offset;
    logic  taken;

    dlx_forward forward_i (
        .rs1      (id_ex.rs1),
        .rs2      (id_ex.rs2),
        .op_a_reg (id_ex.op_a),
        .op_b_reg (id_ex.op_b),
        .ex_mem   (ex_mem.mem),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_value (wb_value),
        .op_a     (op_a),
        .op_b     (op_b)
    );

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            `DLX_ALU_SUB: alu_result = op_a - alu_b;
            `DLX_ALU_AND: alu_result = op_a & alu_b;
            `DLX_ALU_OR:  alu_result = op_a | alu_b;
            `DLX_ALU_XOR: alu_result = op_a ^ alu_b;
            `DLX_ALU_SLT: alu_result = {{(`DLX_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default:      alu_result = op_a + alu_b;
        endcase
    end

    // beqz taken on zero and bnez on nonzero
    assign taken  = id_ex.branch && ((op_a == '0) == id_ex.branch_zero);
    assign offset = id_ex.jump ? {{(`DLX_XLEN-26){id_ex.jump_offset[25]}}, id_ex.jump_offset}
                               : id_ex.imm;

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.leap       <= 1'b0;
        end else begin
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.leap       <= taken || id_ex.jump;
        end
    end

    // store data is the forwarded rs2
    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= op_b;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.leap_addr  <= id_ex.pc_plus4 + offset;
    end

    // decode stall keeps a load in MEM away from the EX sources
    load_not_forwarded: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_mem.reg_write && ex_mem.mem_to_reg && (ex_mem.rd != '0))
            |-> ((id_ex.rs1 != ex_mem.rd) && (id_ex.rs2 != ex_mem.rd)));

endmodule

`default_nettype wire

/* source/dlx_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_forward import dlx_pkg::*; (
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  word_t    op_a_reg,
    input  word_t    op_b_reg,
    ex_mem_if.mem    ex_mem,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    input  word_t    wb_value,
    output word_t    op_a,
    output word_t    op_b
);

    logic mem_can_fwd;
    logic wb_can_fwd;

    // load results are not ready in MEM so decode stalls for them
    assign mem_can_fwd = ex_mem.reg_write && !ex_mem.mem_to_reg && (ex_mem.rd != '0);
    assign wb_can_fwd  = wb_we && (wb_rd != '0);

    // newest producer first
    function automatic word_t pick(input reg_idx_t rs, input word_t from_reg);
        if (mem_can_fwd && (ex_mem.rd == rs)) begin
            return ex_mem.alu_result;
        end else if (wb_can_fwd && (wb_rd == rs)) begin
            return wb_value;
        end
        return from_reg;
    endfunction

    always_comb begin
        op_a = pick(rs1, op_a_reg);
        op_b = pick(rs2, op_b_reg);
    end

endmodule

`default_nettype wire

/* source/dlx_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_reg_file import dlx_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    a,
    output word_t    b,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    input  word_t    wb_value
);

    localparam int NUM_REGS = 1 << `DLX_REG_IDX_W;

    word_t regs [NUM_REGS];

    // r0 reads zero and a same-cycle write shows through
    function automatic word_t read_port(input reg_idx_t idx, input word_t stored);
        if (idx == '0) begin
            return '0;
        end else if (wb_we && (wb_rd == idx)) begin
            return wb_value;
        end
        return stored;
    endfunction

    always_comb begin
        a = read_port(rs1, regs[rs1]);
        b = read_port(rs2, regs[rs2]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_value;
        end
    end

endmodule

`default_nettype wire

/* source/dlx_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_decode import dlx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     if_pc_plus4,
    input  word_t     if_instr,
    input  word_t     imem_data,
    output reg_idx_t  rf_rs1,
    output reg_idx_t  rf_rs2,
    input  word_t     rf_a,
    input  word_t     rf_b,
    output logic      stall,
    id_ex_if.decode   id_ex
);

    opcode_t  opcode;
    funct_t   funct;
    imm16_t   imm16;
    reg_idx_t dest;
    word_t    imm_ext;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     writes;
    logic     mem_to_reg;
    logic     mem_write;
    logic     branch;
    logic     branch_zero;
    logic     jump;

    assign opcode = if_instr[31:26];
    assign funct  = if_instr[5:0];
    assign imm16  = if_instr[15:0];
    assign rf_rs1 = if_instr[25:21];
    assign rf_rs2 = if_instr[20:16];

    //////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////
    always_comb begin
        alu_op      = `DLX_ALU_ADD;
        use_imm     = 1'b0;
        writes      = 1'b0;
        mem_to_reg  = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        branch_zero = 1'b0;
        jump        = 1'b0;
        dest        = if_instr[20:16];
        imm_ext     = {{(`DLX_XLEN-16){imm16[15]}}, imm16};
        case (opcode)
            `DLX_OP_RTYPE: begin
                dest   = if_instr[15:11];
                writes = 1'b1;
                case (funct)
                    `DLX_FN_ADD: alu_op = `DLX_ALU_ADD;
                    `DLX_FN_SUB: alu_op = `DLX_ALU_SUB;
                    `DLX_FN_AND: alu_op = `DLX_ALU_AND;
                    `DLX_FN_OR:  alu_op = `DLX_ALU_OR;
                    `DLX_FN_XOR: alu_op = `DLX_ALU_XOR;
                    `DLX_FN_SLT: alu_op = `DLX_ALU_SLT;
                    default:     writes = 1'b0;  // unknown function is a no-op
                endcase
            end
            `DLX_OP_ADDI: begin
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            `DLX_OP_ANDI, `DLX_OP_ORI: begin
                use_imm = 1'b1;
                writes  = 1'b1;
                alu_op  = (opcode == `DLX_OP_ANDI) ? `DLX_ALU_AND : `DLX_ALU_OR;
                // logical immediates are zero extended
                imm_ext = {{(`DLX_XLEN-16){1'b0}}, imm16};
            end
            `DLX_OP_LW: begin
                use_imm    = 1'b1;
                writes     = 1'b1;
                mem_to_reg = 1'b1;
            end
            `DLX_OP_SW: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            `DLX_OP_BEQZ, `DLX_OP_BNEZ: begin
                branch      = 1'b1;
                branch_zero = (opcode == `DLX_OP_BEQZ);
            end
            `DLX_OP_J: jump = 1'b1;
            default: ;
        endcase
    end

    // load-use hazard against both source fields of the fetched word
    assign stall = (opcode == `DLX_OP_LW) && (dest != '0) &&
                   ((imem_data[25:21] == dest) || (imem_data[20:16] == dest));

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.alu_op      <= `DLX_ALU_ADD;
            id_ex.use_imm     <= 1'b0;
            id_ex.reg_write   <= 1'b0;
            id_ex.mem_to_reg  <= 1'b0;
            id_ex.mem_write   <= 1'b0;
            id_ex.branch      <= 1'b0;
            id_ex.branch_zero <= 1'b0;
            id_ex.jump        <= 1'b0;
        end else begin
            id_ex.alu_op      <= alu_op;
            id_ex.use_imm     <= use_imm;
            id_ex.reg_write   <= writes && (dest != '0);  // r0 stays zero
            id_ex.mem_to_reg  <= mem_to_reg;
            id_ex.mem_write   <= mem_write;
            id_ex.branch      <= branch;
            id_ex.branch_zero <= branch_zero;
            id_ex.jump        <= jump;
        end
    end

    // operands and fields
    always_ff @(posedge clk) begin
        id_ex.pc_plus4    <= if_pc_plus4;
        id_ex.op_a        <= rf_a;
        id_ex.op_b        <= rf_b;
        id_ex.imm         <= imm_ext;
        id_ex.rs1         <= rf_rs1;
        id_ex.rs2         <= rf_rs2;
        id_ex.rd          <= dest;
        id_ex.jump_offset <= if_instr[25:0];
    end

    no_write_to_r0: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex.reg_write |-> (id_ex.rd != '0));

endmodule

`default_nettype wire

/* source/dlx_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_fetch import dlx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    ex_mem_if.fetch   ex_mem,
    input  word_t     imem_data,
    output word_t     imem_addr,
    output word_t     if_pc_plus4,
    output word_t     if_instr
);

    word_t pc;
    word_t pc_plus4;

    assign pc_plus4  = pc + `DLX_XLEN'd4;
    assign imem_addr = pc;

    // leap from EX/MEM wins over the load-use hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `DLX_RESET_PC;
        end else if (ex_mem.leap) begin
            pc <= ex_mem.leap_addr;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    // IF/ID register with a zero-word bubble on stall
    always_ff @(posedge clk) begin
        if_pc_plus4 <= pc_plus4;
        if (!rst_n || stall) begin
            if_instr <= '0;
        end else begin
            if_instr <= imem_data;
        end
    end

    // redirect lands even while decode asks for a stall
    leap_redirects_pc: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem.leap |=> (pc == $past(ex_mem.leap_addr)));

endmodule

`default_nettype wire

/* source/dlx_pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// ID/EX stage register contents
interface id_ex_if import dlx_pkg::*; ();
    word_t    pc_plus4;
    word_t    op_a;
    word_t    op_b;
    word_t    imm;          // already extended
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_write;
    logic     branch;
    logic     branch_zero;  // set for beqz
    logic     jump;
    imm26_t   jump_offset;

    modport decode (output pc_plus4, op_a, op_b, imm, rs1, rs2, rd, alu_op, use_imm,
        reg_write, mem_to_reg, mem_write, branch, branch_zero, jump, jump_offset);

    modport execute (input pc_plus4, op_a, op_b, imm, rs1, rs2, rd, alu_op, use_imm,
        reg_write, mem_to_reg, mem_write, branch, branch_zero, jump, jump_offset);
endinterface

// EX/MEM stage register contents
interface ex_mem_if import dlx_pkg::*; ();
    word_t    alu_result;   // also the data memory address
    word_t    store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_write;
    logic     leap;         // taken branch or jump
    word_t    leap_addr;

    modport execute (output alu_result, store_data, rd, reg_write, mem_to_reg, mem_write,
        leap, leap_addr);
    modport mem (input alu_result, rd, reg_write, mem_to_reg);
    modport fetch (input leap, leap_addr);
endinterface

`default_nettype wire

/* source/dlx_pkg.sv */
`default_nettype none

`include "dlx_cfg.svh"

package dlx_pkg;

    // data word, byte address or instruction
    typedef logic [`DLX_XLEN-1:0] word_t;

    // register number
    typedef logic [`DLX_REG_IDX_W-1:0] reg_idx_t;

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // alu operation select (DLX_ALU_* codes)
    typedef logic [3:0] alu_op_t;

    // raw immediates before extension
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] imm26_t;

endpackage

`default_nettype wire

/* source/dlx_cfg.svh */
`ifndef DLX_CFG_SVH
`define DLX_CFG_SVH

// datapath and register index widths
`define DLX_XLEN       32
`define DLX_REG_IDX_W  5

// first fetch address out of reset
`define DLX_RESET_PC   32'h0000_0000

// primary opcodes, bits 31:26
`define DLX_OP_RTYPE   6'h00
`define DLX_OP_J       6'h02
`define DLX_OP_BEQZ    6'h04
`define DLX_OP_BNEZ    6'h05
`define DLX_OP_ADDI    6'h08
`define DLX_OP_ANDI    6'h0c
`define DLX_OP_ORI     6'h0d
`define DLX_OP_LW      6'h23
`define DLX_OP_SW      6'h2b

// r-type function field, bits 5:0
`define DLX_FN_ADD     6'h20
`define DLX_FN_SUB     6'h22
`define DLX_FN_AND     6'h24
`define DLX_FN_OR      6'h25
`define DLX_FN_XOR     6'h26
`define DLX_FN_SLT     6'h2a

// internal alu operations
`define DLX_ALU_ADD    4'd0
`define DLX_ALU_SUB    4'd1
`define DLX_ALU_AND    4'd2
`define DLX_ALU_OR     4'd3
`define DLX_ALU_XOR    4'd4
`define DLX_ALU_SLT    4'd5

`endif
